//--- filelist.f
hw/dct_pkg.sv
hw/dct_mac.sv
hw/dct_1d.sv
hw/transpose_buf.sv
hw/dct_2d_top.sv
sim/dct_2d_props.sv
sim/tb_dct_2d.sv

//--- run_sim.sh
#!/bin/sh
# build and run the 2-d DCT testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dct_2d -Mdir obj_dir -f filelist.f

# assertion errors must not end the run early
out=$(./obj_dir/Vtb_dct_2d +verilator+error+limit+1000 2>&1) || true
echo "$out"

echo "$out" | grep -q "TESTBENCH PASSED"

//--- sim/tb_dct_2d.sv
`default_nettype none

module tb_dct_2d;

   localparam int NUM_BLOCKS = 13;
   localparam int NUM_EXP    = NUM_BLOCKS * 64;
   // cycle budget for the whole run
   localparam int LIMIT      = NUM_BLOCKS * 64 * 2 + 200;

   logic                      CLK;
   logic                      RST;
   dct_pkg::pix_beat_t        pix_in;
   dct_pkg::coef_beat_t       dct_out;

   integer                    seed;
   // current block indexed as blk[row][column]
   int                        blk [8][8];
   // expected results in output order, filled before each block is sent
   logic [dct_pkg::OUT_W-1:0] exp_mem [NUM_EXP];
   int                        exp_wr;
   int                        exp_rd;
   logic [dct_pkg::OUT_W-1:0] exp_head;
   int                        cycle_cnt;
   int                        data_errs;
   int                        extra_errs;
   int                        missing_errs;
   int                        wrap_errs;
   int                        total_errs;

   dct_2d_top dct_2d_top_i (
      .CLK     (CLK),
      .RST     (RST),
      .pix_in  (pix_in),
      .dct_out (dct_out)
   );

   // stream protocol checks inside the top level
   bind dct_2d_top dct_2d_props props_i (
      .CLK       (CLK),
      .RST       (RST),
      .pix_in    (pix_in),
      .dct_out   (dct_out),
      .row_valid (row_beat.valid)
   );

   initial CLK = 1'b0;
   always #4 CLK = ~CLK;

   assign exp_head = (exp_rd < NUM_EXP) ? exp_mem[exp_rd] : '0;

   // one expected value is consumed per output beat
   always @(posedge CLK)
   begin
      if (!RST && dct_out.valid)
         exp_rd <= exp_rd + 1;
   end

   // every output matches the oldest pending expected value
   check_data: assert property (@(posedge CLK) disable iff (RST)
      (dct_out.valid && (exp_rd < exp_wr)) |-> (dct_out.data == exp_head))
   else
   begin
      data_errs++;
      $display("Error dct_out.data expected %h got %h at output %0d",
               $sampled(exp_head), $sampled(dct_out.data), $sampled(exp_rd));
   end

   // no output beyond what was sent
   check_extra: assert property (@(posedge CLK) disable iff (RST)
      dct_out.valid |-> (exp_rd < exp_wr))
   else
   begin
      extra_errs++;
      $display("dct_out.valid was high with no result pending at cycle %0d", cycle_cnt);
   end

   task automatic report_counts();
      $display("errors: data %0d, unexpected %0d, missing %0d, wrap %0d, protocol %0d",
               data_errs, extra_errs, missing_errs, wrap_errs,
               dct_2d_top_i.props_i.fail_cnt);
   endtask

   // run limit
   always @(posedge CLK)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= LIMIT)
      begin
         $display("run timed out after %0d cycles with %0d results outstanding",
                  cycle_cnt, exp_wr - exp_rd);
         report_counts();
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // shift out the dropped fraction, add its top bit, keep w bits signed
   function automatic int round_result(input int s, input int w);
      int r;
      r = (s >>> dct_pkg::FRAC_W) + ((s >>> (dct_pkg::FRAC_W - 1)) & 1);
      // a stage result has to fit its width with no wrap
      if (r >= (1 << (w - 1)) || r < -(1 << (w - 1)))
      begin
         wrap_errs++;
         $display("rounded result %0d does not fit in %0d bits", r, w);
      end
      r = r & ((1 << w) - 1);
      if (r >= (1 << (w - 1)))
         r = r - (1 << w);
      return r;
   endfunction

   // one point of the 8-point transform where s[0] is the first sample in
   function automatic int dct_point(input int s [8], input int k, input int w);
      dct_pkg::coef_t c;
      int             acc;
      int             pv;
      int             cv;
      acc = 0;
      for (int j = 0; j < 4; j++)
      begin
         // sums for even k, differences for odd k
         pv  = (k % 2 == 1) ? s[j] - s[7-j] : s[j] + s[7-j];
         c   = dct_pkg::dct_coef(3'(k), 2'(j));
         cv  = c.neg ? -int'(c.mag) : int'(c.mag);
         acc = acc + pv * cv;
      end
      return round_result(acc, w);
   endfunction

   // rows then columns
   // results queued as column u then frequency v
   task automatic push_expected();
      int vec [8];
      int y   [8][8];
      for (int r = 0; r < 8; r++)
      begin
         for (int c = 0; c < 8; c++)
            vec[c] = blk[r][c];
         for (int k = 0; k < 8; k++)
            y[r][k] = dct_point(vec, k, dct_pkg::ROW_W);
      end
      for (int u = 0; u < 8; u++)
      begin
         for (int r = 0; r < 8; r++)
            vec[r] = y[r][u];
         for (int v = 0; v < 8; v++)
            exp_mem[exp_wr + u * 8 + v] = dct_pkg::OUT_W'(dct_point(vec, v, dct_pkg::OUT_W));
      end
      exp_wr = exp_wr + 64;
   endtask

   task automatic fill_const(input int c);
      for (int r = 0; r < 8; r++)
         for (int k = 0; k < 8; k++)
            blk[r][k] = c;
   endtask

   task automatic fill_random();
      for (int r = 0; r < 8; r++)
         for (int k = 0; k < 8; k++)
            blk[r][k] = ($random(seed) % 128);
   endtask

   // alternating extremes
   task automatic fill_checker();
      for (int r = 0; r < 8; r++)
         for (int k = 0; k < 8; k++)
            blk[r][k] = ((r + k) % 2 == 1) ? 127 : -128;
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(posedge CLK);
         pix_in.valid <= 1'b0;
      end
   endtask

   // row-major send with optional random gaps and a pause before the last pixel
   task automatic send_block(input bit gaps, input int last_pause, input int tail_gap);
      push_expected();
      for (int r = 0; r < 8; r++)
      begin
         for (int k = 0; k < 8; k++)
         begin
            if (r == 7 && k == 7)
               idle_cycles(last_pause);
            if (gaps)
            begin
               while ($random(seed) % 4 == 0)
                  idle_cycles(1);
            end
            @(posedge CLK);
            pix_in.valid <= 1'b1;
            pix_in.data  <= dct_pkg::PIX_W'(blk[r][k]);
         end
      end
      idle_cycles(tail_gap);
   endtask

   initial
   begin
      seed         = 32'hfecbb3d2;
      RST          = 1'b1;
      pix_in       = '0;
      exp_wr       = 0;
      exp_rd       = 0;
      cycle_cnt    = 0;
      data_errs    = 0;
      extra_errs   = 0;
      missing_errs = 0;
      wrap_errs    = 0;
      repeat (3) @(posedge CLK);
      RST <= 1'b0;
      repeat (2) @(posedge CLK);

      // first block holds back its last pixel so the output has to wait for it
      fill_const(37);
      send_block(1'b0, 24, 3);
      fill_const(-90);
      send_block(1'b0, 0, 5);

      // back-to-back random blocks with valid held high
      for (int b = 0; b < 4; b++)
      begin
         fill_random();
         send_block(1'b0, 0, 0);
      end
      idle_cycles(2);

      // random gaps inside and between blocks
      for (int b = 0; b < 4; b++)
      begin
         fill_random();
         send_block(1'b1, 0, $unsigned($random(seed)) % 16);
      end

      // full-scale inputs
      fill_const(-128);
      send_block(1'b0, 0, 0);
      fill_const(127);
      send_block(1'b0, 0, 0);
      fill_checker();
      send_block(1'b0, 0, 1);

      // bounded wait for the last results
      for (int i = 0; i < 400 && exp_rd != exp_wr; i++)
         @(posedge CLK);
      if (exp_rd != exp_wr)
      begin
         missing_errs = exp_wr - exp_rd;
         $display("%0d expected results never appeared on dct_out", missing_errs);
      end
      // stray beats after the last block would still be caught here
      repeat (20) @(posedge CLK);

      report_counts();
      total_errs = data_errs + extra_errs + missing_errs + wrap_errs
                   + dct_2d_top_i.props_i.fail_cnt;
      if (total_errs == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/dct_2d_props.sv
`default_nettype none

module dct_2d_props (
   input logic                CLK,
   input logic                RST,
   input dct_pkg::pix_beat_t  pix_in,
   input dct_pkg::coef_beat_t dct_out,
   input logic                row_valid
);

   // accepted pixels, stops at one full block
   logic [6:0] pix_seen;
   // position inside the current output block
   logic [5:0] out_pos;
   // position inside the current row stage group
   logic [2:0] row_pos;
   // failed assertions, read by the testbench
   int         fail_cnt = 0;

   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         pix_seen <= '0;
         out_pos  <= '0;
         row_pos  <= '0;
      end
      else
      begin
         if (pix_in.valid && (pix_seen < 7'd64))
            pix_seen <= pix_seen + 7'd1;
         if (dct_out.valid)
            out_pos <= out_pos + 6'd1;
         if (row_valid)
            row_pos <= row_pos + 3'd1;
      end
   end

   // nothing comes out before a whole block went in
   no_early_out: assert property (@(posedge CLK) disable iff (RST)
      (pix_seen < 7'd64) |-> !dct_out.valid)
   else
   begin
      fail_cnt++;
      $error("dct_out.valid went high before a full block was received");
   end

   // a block's 64 results are never split
   out_burst: assert property (@(posedge CLK) disable iff (RST)
      (out_pos != 6'd0) |-> dct_out.valid)
   else
   begin
      fail_cnt++;
      $error("dct_out.valid dropped inside a 64 result burst");
   end

   // row results come in unbroken runs of 8
   row_burst: assert property (@(posedge CLK) disable iff (RST)
      (row_pos != 3'd0) |-> row_valid)
   else
   begin
      fail_cnt++;
      $error("row stage valid dropped inside an 8 result run");
   end

endmodule

`default_nettype wire

//--- hw/dct_2d_top.sv
`default_nettype none

module dct_2d_top (
   input  logic                CLK,
   input  logic                RST,
   input  dct_pkg::pix_beat_t  pix_in,
   output dct_pkg::coef_beat_t dct_out
);

   // row stage results, written row by row
   dct_pkg::row_beat_t row_beat;
   // transposed results, read column by column
   dct_pkg::row_beat_t col_beat;

   // first 1-d transform over the rows of the block
   dct_1d #(
      .IN_W  (dct_pkg::PIX_W),
      .OUT_W (dct_pkg::ROW_W)
   ) dct_row_i (
      .CLK       (CLK),
      .RST       (RST),
      .in_valid  (pix_in.valid),
      .in_data   (pix_in.data),
      .out_valid (row_beat.valid),
      .out_data  (row_beat.data)
   );

   // ping-pong memory turning rows into columns
   transpose_buf transpose_buf_i (
      .CLK (CLK),
      .RST (RST),
      .wr  (row_beat),
      .rd  (col_beat)
   );

   // second 1-d transform over the columns
   // output order is column u then vertical frequency v
   dct_1d #(
      .IN_W  (dct_pkg::ROW_W),
      .OUT_W (dct_pkg::OUT_W)
   ) dct_col_i (
      .CLK       (CLK),
      .RST       (RST),
      .in_valid  (col_beat.valid),
      .in_data   (col_beat.data),
      .out_valid (dct_out.valid),
      .out_data  (dct_out.data)
   );

endmodule

`default_nettype wire

//--- hw/transpose_buf.sv
`default_nettype none

module transpose_buf (
   input  logic               CLK,
   input  logic               RST,
   input  dct_pkg::row_beat_t wr,
   output dct_pkg::row_beat_t rd
);

   // one 8x8 block per bank
   localparam int DEPTH = dct_pkg::DCT_N * dct_pkg::DCT_N;
   localparam int AW    = $clog2(DEPTH);
   // bits of row index and of column index
   localparam int HW    = AW / 2;

   // two banks, one filling while the other drains
   logic [dct_pkg::ROW_W-1:0] mem [2][DEPTH];

   // write side, address is r*8 + k
   logic [AW-1:0]             wr_addr;
   logic                      fill_sel;
   logic                      swap;

   // read side
   logic [AW-1:0]             rd_cnt;
   logic                      rd_act;
   logic [AW-1:0]             rd_addr;
   logic [dct_pkg::ROW_W-1:0] rd_data;
   logic                      rd_valid;

   // last word of the fill bank lands on this edge
   assign swap = wr.valid && (wr_addr == AW'(DEPTH - 1));

   // rd_cnt is u*8 + r, the bank is addressed at r*8 + u
   assign rd_addr = {rd_cnt[HW-1:0], rd_cnt[AW-1:HW]};

   // write and bank control
   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         wr_addr  <= '0;
         fill_sel <= 1'b0;
      end
      else if (wr.valid)
      begin
         // wraps to 0 after the 64th word
         wr_addr <= wr_addr + 1'b1;
         if (swap)
         begin
            fill_sel <= ~fill_sel;
         end
      end
   end

   always_ff @(posedge CLK)
   begin
      if (wr.valid)
      begin
         mem[fill_sel][wr_addr] <= wr.data;
      end
   end

   // read sequencer, 64 reads from the cycle after a swap
   // a new swap may land on the 64th read and keeps the reads going
   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         rd_cnt   <= '0;
         rd_act   <= 1'b0;
         rd_valid <= 1'b0;
      end
      else
      begin
         rd_valid <= rd_act;
         if (swap)
         begin
            rd_act <= 1'b1;
            rd_cnt <= '0;
         end
         else if (rd_act)
         begin
            rd_cnt <= rd_cnt + 1'b1;
            if (rd_cnt == AW'(DEPTH - 1))
            begin
               rd_act <= 1'b0;
            end
         end
      end
   end

   // the bank not being filled is the one being read
   always_ff @(posedge CLK)
   begin
      if (rd_act)
      begin
         rd_data <= mem[~fill_sel][rd_addr];
      end
   end

   assign rd.valid = rd_valid;
   assign rd.data  = rd_data;

endmodule

`default_nettype wire

//--- hw/dct_1d.sv
`default_nettype none

module dct_1d #(
   parameter int IN_W  = 8,
   parameter int OUT_W = 11
) (
   input  logic             CLK,
   input  logic             RST,
   input  logic             in_valid,
   input  logic [IN_W-1:0]  in_data,
   output logic             out_valid,
   output logic [OUT_W-1:0] out_data
);

   localparam int N  = dct_pkg::DCT_N;
   // sign-extended sample
   localparam int XW = IN_W + 1;
   // sum or difference of two samples
   localparam int PW = IN_W + 2;

   // sample shift register, sr[0] newest
   logic [IN_W-1:0]        sr [N];
   // valid samples seen in the current group of eight
   logic [2:0]             cnt;
   // eighth sample has just been shifted in
   logic                   full;
   // latched vector, x[7] is the first sample of the group and x[0] the eighth
   logic signed [XW-1:0]   x [N];
   // issue in progress and output index
   logic                   busy;
   logic [2:0]             k;
   // butterfly values for the current index
   logic [N/2-1:0][PW-1:0] pair;

   // group counter and full flag
   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         cnt  <= '0;
         full <= 1'b0;
      end
      else
      begin
         full <= in_valid && (cnt == 3'(N - 1));
         if (in_valid)
         begin
            // wraps after the eighth sample
            cnt <= cnt + 3'd1;
         end
      end
   end

   // shift only on valid samples so gaps are skipped
   always_ff @(posedge CLK)
   begin
      if (in_valid)
      begin
         sr[0] <= in_data;
         for (int i = 1; i < N; i++)
         begin
            sr[i] <= sr[i-1];
         end
      end
   end

   // latch the group one cycle after its last sample
   // the shift register may already take the next group on the same edge
   always_ff @(posedge CLK)
   begin
      if (full)
      begin
         for (int i = 0; i < N; i++)
         begin
            x[i] <= {sr[i][IN_W-1], sr[i]};
         end
      end
   end

   // walk k from 0 to 7 on consecutive cycles after each latch
   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         busy <= 1'b0;
         k    <= '0;
      end
      else if (full)
      begin
         // a new group restarts the index even on the last issue cycle
         busy <= 1'b1;
         k    <= '0;
      end
      else if (busy)
      begin
         k <= k + 3'd1;
         if (k == 3'(N - 1))
         begin
            busy <= 1'b0;
         end
      end
   end

   // even k uses sums, odd k uses differences, as the reference toggle
   always_comb
   begin
      for (int j = 0; j < N / 2; j++)
      begin
         if (k[0])
            pair[j] = x[N-1-j] - x[j];
         else
            pair[j] = x[j] + x[N-1-j];
      end
   end

   // multiply, accumulate and round, 5 cycles
   dct_mac #(
      .IN_W  (IN_W),
      .OUT_W (OUT_W)
   ) dct_mac_i (
      .CLK       (CLK),
      .RST       (RST),
      .issue     (busy),
      .idx       (k),
      .pair      (pair),
      .out_valid (out_valid),
      .out_data  (out_data)
   );

endmodule

`default_nettype wire

//--- hw/dct_mac.sv
`default_nettype none

module dct_mac #(
   parameter int IN_W  = 8,
   parameter int OUT_W = 11
) (
   input  logic                                 CLK,
   input  logic                                 RST,
   input  logic                                 issue,
   input  logic [2:0]                           idx,
   input  logic [dct_pkg::DCT_N/2-1:0][IN_W+1:0] pair,
   output logic                                 out_valid,
   output logic [OUT_W-1:0]                     out_data
);

   // taps per output
   localparam int NT    = dct_pkg::DCT_N / 2;
   localparam int PW    = IN_W + 2;
   // unsigned product of pair magnitude and cosine magnitude
   localparam int PRD_W = PW + dct_pkg::CMAG_W;
   // signed product plus two adder levels
   localparam int SUM_W = PRD_W + 3;

   // coefficients for the issued index
   dct_pkg::coef_t           cf [NT];

   // stage 1, magnitude and combined sign
   logic [PW-1:0]            mag1 [NT];
   logic [dct_pkg::CMAG_W-1:0] cmag1 [NT];
   logic                     sgn1 [NT];
   // stage 2, unsigned product
   logic [PRD_W-1:0]         prod2 [NT];
   logic                     sgn2 [NT];
   // stage 3, signed product
   logic signed [PRD_W:0]    p3 [NT];
   // stage 4, pair sums
   logic signed [PRD_W+1:0]  sum4 [2];
   // stage 5, total
   logic signed [SUM_W-1:0]  tot;
   logic signed [SUM_W-1:0]  tot_sh;

   // valid bit per stage
   logic [4:0]               vld;

   // table lookup, one constant per tap
   always_comb
   begin
      for (int j = 0; j < NT; j++)
      begin
         cf[j] = dct_pkg::dct_coef(idx, 2'(j));
      end
   end

   // datapath, free running
   always_ff @(posedge CLK)
   begin
      for (int j = 0; j < NT; j++)
      begin
         // two's complement to sign-magnitude
         mag1[j]  <= pair[j][PW-1] ? -pair[j] : pair[j];
         // product is negative when exactly one factor is
         sgn1[j]  <= pair[j][PW-1] ^ cf[j].neg;
         cmag1[j] <= cf[j].mag;

         prod2[j] <= mag1[j] * cmag1[j];
         sgn2[j]  <= sgn1[j];

         // back to two's complement with one extra sign bit
         p3[j] <= sgn2[j] ? -$signed({1'b0, prod2[j]}) : $signed({1'b0, prod2[j]});
      end

      // two-level adder tree
      sum4[0] <= p3[0] + p3[1];
      sum4[1] <= p3[2] + p3[3];
      tot     <= sum4[0] + sum4[1];
   end

   // valid travels alongside the data
   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         vld <= '0;
      end
      else
      begin
         vld <= {vld[3:0], issue};
      end
   end

   assign out_valid = vld[4];

   // arithmetic shift, then add the highest dropped bit
   assign tot_sh   = tot >>> dct_pkg::FRAC_W;
   // no saturation, the result always fits in OUT_W
   assign out_data = tot_sh[OUT_W-1:0] + OUT_W'(tot[dct_pkg::FRAC_W-1]);

endmodule

`default_nettype wire

//--- hw/dct_pkg.sv
`default_nettype none

package dct_pkg;

   // points per one-dimensional transform
   parameter int DCT_N = 8;

   // signed input pixel
   parameter int PIX_W = 8;
   // row stage result as stored in the transpose memory
   parameter int ROW_W = 11;
   // final 2-d coefficient
   parameter int OUT_W = 12;

   // cosine magnitudes are scaled by 128 and fit in 7 bits
   parameter int CMAG_W = 7;
   // bits dropped when the sum of products is rounded
   parameter int FRAC_W = 8;

   // sign-magnitude cosine constant as used by the multipliers
   typedef struct packed {
      logic              neg;
      logic [CMAG_W-1:0] mag;
   } coef_t;

   // one pixel on the input stream
   typedef struct packed {
      logic             valid;
      logic [PIX_W-1:0] data;
   } pix_beat_t;

   // one row stage result, into and out of the transpose memory
   typedef struct packed {
      logic             valid;
      logic [ROW_W-1:0] data;
   } row_beat_t;

   // one 2-d coefficient on the output stream
   typedef struct packed {
      logic             valid;
      logic [OUT_W-1:0] data;
   } coef_beat_t;

   // coefficient for output index k and tap j
   // tap j multiplies the pair built from samples j and 7-j
   // magnitudes are round(128 * cos(m * pi / 16)) for m = 4, 1, 2, 3, 4, 5, 6, 7
   function automatic coef_t dct_coef(input logic [2:0] k, input logic [1:0] j);
      int    tap [4];
      coef_t c;
      case (k)
         3'd0: tap = '{91, 91, 91, 91};
         3'd1: tap = '{126, 106, 71, 25};
         3'd2: tap = '{118, 49, -49, -118};
         3'd3: tap = '{106, -25, -126, -71};
         3'd4: tap = '{91, -91, -91, 91};
         3'd5: tap = '{71, -126, 25, 106};
         3'd6: tap = '{49, -118, 118, -49};
         3'd7: tap = '{25, -71, 106, -126};
      endcase
      // split into sign flag and magnitude
      c.neg = (tap[j] < 0);
      c.mag = CMAG_W'(c.neg ? -tap[j] : tap[j]);
      return c;
   endfunction

endpackage

`default_nettype wire
